//--- dot_driver.f
rtl/dot_driver_pkg.sv
rtl/spi_frame_receiver.sv
rtl/update_controller.sv
rtl/driver_core.sv
rtl/dot_driver_top.sv
verification/dot_driver_sva.sv
verification/dot_driver_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dot_driver_tb
FILELIST  ?= dot_driver.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard rtl/*.sv verification/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/dot_driver_tb.sv
`timescale 1ns/1ps

module dot_driver_tb;

  import dot_driver_pkg::*;

  localparam int NUM_OF_DRIVERS  = 8;
  localparam int MEM_LENGTH      = 48;
  localparam int SPI_HALF_PERIOD = 4;
  localparam int WRITE_SETTLE    = 6;
  // three full cores plus a handful of single frames
  localparam int NUM_FRAMES      = 3 * MEM_LENGTH + 16;
  localparam int NUM_SCANS       = 8;
  localparam int FRAME_CYCLES    = 2 * SPI_HALF_PERIOD * FRAME_BITS + SPI_HALF_PERIOD + 8;
  localparam int TIMEOUT_CYCLES  = 2 * (NUM_FRAMES * FRAME_CYCLES + NUM_SCANS * (MEM_LENGTH + 6));

  logic        clk;
  logic        arst_n;
  logic        sclk;
  logic        mosi;
  logic        ss_n;
  logic        latch_data;
  logic        control_trigger;
  dot_data_t   driver_io [NUM_OF_DRIVERS];
  logic        update_done;
  int          cycle_cnt;
  logic [31:0] rng_state;

  // reference model, banks indexed like the DUT bank bit
  dot_data_t model_mem [NUM_OF_DRIVERS][2][MEM_LENGTH];
  logic      model_inv [NUM_OF_DRIVERS];
  logic      model_bank;

  dot_driver_top #(
    .NUM_OF_DRIVERS (NUM_OF_DRIVERS),
    .MEM_LENGTH     (MEM_LENGTH)
  ) u_dut (
    .user_clock2_i     (clk),
    .arst_n_i          (arst_n),
    .sclk_i            (sclk),
    .mosi_i            (mosi),
    .ss_n_i            (ss_n),
    .latch_data_i      (latch_data),
    .control_trigger_i (control_trigger),
    .driver_io_o       (driver_io),
    .update_done_o     (update_done)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic dot_data_t next_dot();
    rng_state = xorshift32(rng_state);
    return rng_state[5:4];
  endfunction

  // msb first: cmd, idx, addr, data
  function automatic frame_t make_frame(input wr_cmd_e cmd, input drv_idx_t idx,
                                        input mem_addr_t addr, input dot_data_t data);
    return {cmd, idx, addr, data};
  endfunction

  function automatic dot_data_t expected_dot(input int core, input int addr);
    return model_mem[core][model_bank][addr] ^ {2{model_inv[core]}};
  endfunction

  task automatic check_dot(input string name, input dot_data_t got, input dot_data_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "first error, run stopped");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "first error, run stopped");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // bit-bang the first nbits of a frame, then deselect
  task automatic spi_send_bits(input frame_t frame, input int nbits);
    @(posedge clk);
    ss_n <= 1'b0;
    for (int b = 0; b < nbits; b++) begin
      mosi <= frame[FRAME_BITS-1-b];
      wait_cycles(SPI_HALF_PERIOD);
      sclk <= 1'b1;
      wait_cycles(SPI_HALF_PERIOD);
      sclk <= 1'b0;
    end
    wait_cycles(SPI_HALF_PERIOD);
    ss_n <= 1'b1;
    mosi <= 1'b0;
    wait_cycles(WRITE_SETTLE);
  endtask

  task automatic write_pattern(input drv_idx_t idx, input mem_addr_t addr, input dot_data_t data);
    spi_send_bits(make_frame(WR_PATTERN, idx, addr, data), FRAME_BITS);
    if (idx < NUM_OF_DRIVERS) begin
      model_mem[idx][!model_bank][addr] = data;
    end
  endtask

  task automatic write_config(input drv_idx_t idx, input logic flag);
    spi_send_bits(make_frame(WR_CONFIG, idx, '0, {1'b0, flag}), FRAME_BITS);
    model_inv[idx] = flag;
  endtask

  task automatic latch();
    @(posedge clk);
    latch_data <= 1'b1;
    @(posedge clk);
    latch_data <= 1'b0;
    model_bank = !model_bank;
  endtask

  task automatic check_idle();
    for (int c = 0; c < NUM_OF_DRIVERS; c++) begin
      check_dot($sformatf("driver_io_o[%0d]", c), driver_io[c], '0);
    end
    check_bit("update_done_o", update_done, 1'b0);
  endtask

  // trigger and follow one update cycle, poke_k pulses latch and trigger mid-scan
  task automatic run_scan(input int poke_k);
    @(posedge clk);
    control_trigger <= 1'b1;
    @(posedge clk);
    control_trigger <= 1'b0;
    for (int k = 0; k < MEM_LENGTH; k++) begin
      @(posedge clk);
      latch_data      <= (k == poke_k);
      control_trigger <= (k == poke_k);
      @(negedge clk);
      for (int c = 0; c < NUM_OF_DRIVERS; c++) begin
        check_dot($sformatf("driver_io_o[%0d]", c), driver_io[c], expected_dot(c, k));
      end
      check_bit("update_done_o", update_done, k == MEM_LENGTH - 1);
    end
    repeat (3) begin
      @(negedge clk);
      check_idle();
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_idle();
    run_scan(-1);
  endtask

  task automatic test_pattern_playback();
    int cores [3];
    cores = '{0, 3, NUM_OF_DRIVERS - 1};
    foreach (cores[i]) begin
      for (int a = 0; a < MEM_LENGTH; a++) begin
        write_pattern(drv_idx_t'(cores[i]), mem_addr_t'(a), next_dot());
      end
    end
    latch();
    run_scan(-1);
  endtask

  task automatic test_double_buffering();
    // inverse of the playing value so old and new always differ
    for (int a = 0; a < 12; a++) begin
      write_pattern(drv_idx_t'(3), mem_addr_t'(a), ~model_mem[3][model_bank][a]);
    end
    run_scan(-1);
    latch();
    run_scan(-1);
  endtask

  task automatic test_inverter_select();
    write_config(drv_idx_t'(0), 1'b1);
    run_scan(-1);
  endtask

  task automatic test_ignored_inputs();
    run_scan(10);
    // cmd, idx and three address bits only
    spi_send_bits(make_frame(WR_PATTERN, drv_idx_t'(0), mem_addr_t'(5),
                             ~model_mem[0][!model_bank][5]), 7);
    // lands intact only if the partial frame was dropped
    write_pattern(drv_idx_t'(5), mem_addr_t'(5), ~model_mem[5][!model_bank][5]);
    if (NUM_OF_DRIVERS < (1 << DRV_IDX_BITS)) begin
      write_pattern(drv_idx_t'(NUM_OF_DRIVERS), mem_addr_t'(5), 2'b11);
    end else begin
      $display("note: every core index is in use, out-of-range write not exercised");
    end
    latch();
    run_scan(-1);
  endtask

  initial begin
    clk             = 1'b0;
    arst_n          = 1'b0;
    sclk            = 1'b0;
    mosi            = 1'b0;
    ss_n            = 1'b1;
    latch_data      = 1'b0;
    control_trigger = 1'b0;
    cycle_cnt       = 0;
    rng_state       = 32'd72;
    model_bank      = 1'b0;
    for (int c = 0; c < NUM_OF_DRIVERS; c++) begin
      model_inv[c] = 1'b0;
      for (int a = 0; a < MEM_LENGTH; a++) begin
        model_mem[c][0][a] = '0;
        model_mem[c][1][a] = '0;
      end
    end
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    test_reset_state();
    test_pattern_playback();
    test_double_buffering();
    test_inverter_select();
    test_ignored_inputs();
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- verification/dot_driver_sva.sv
`timescale 1ns/1ps

module dot_driver_sva #(
  parameter int NUM_OF_DRIVERS = 8,
  parameter int MEM_LENGTH     = 48
) (
  input logic                      clk_i,
  input logic                      arst_n_i,
  input logic                      trigger_i,
  input logic                      scan_active_i,
  input dot_driver_pkg::dot_data_t driver_io_i [NUM_OF_DRIVERS],
  input logic                      update_done_i
);

  logic any_dot;
  logic trigger_accepted;

  always_comb begin
    any_dot = 1'b0;
    for (int i = 0; i < NUM_OF_DRIVERS; i++) begin
      any_dot = any_dot | (|driver_io_i[i]);
    end
  end

  // idle and not in the completion cycle
  assign trigger_accepted = trigger_i && !scan_active_i && !update_done_i;

  done_single_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    update_done_i |=> !update_done_i)
    else $error("update_done_o held high for more than one cycle");

  // output register follows scan.active one cycle later
  idle_outputs_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !scan_active_i |=> !any_dot)
    else $error("driver_io_o not zero outside a scan");

  done_after_trigger: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    trigger_accepted |-> ##(MEM_LENGTH + 1) update_done_i)
    else $error("update_done_o missing %0d cycles after trigger", MEM_LENGTH + 1);

endmodule

bind dot_driver_top dot_driver_sva #(
  .NUM_OF_DRIVERS (NUM_OF_DRIVERS),
  .MEM_LENGTH     (MEM_LENGTH)
) u_sva (
  .clk_i         (user_clock2_i),
  .arst_n_i      (arst_n_i),
  .trigger_i     (control_trigger_i),
  .scan_active_i (scan.active),
  .driver_io_i   (driver_io_o),
  .update_done_i (update_done_o)
);

//--- rtl/dot_driver_top.sv
`timescale 1ns/1ps
`default_nettype none

module dot_driver_top #(
  parameter int NUM_OF_DRIVERS = 8,
  parameter int MEM_LENGTH     = 48
) (
  input  logic                      user_clock2_i,
  input  logic                      arst_n_i,
  input  logic                      sclk_i,
  input  logic                      mosi_i,
  input  logic                      ss_n_i,
  input  logic                      latch_data_i,
  input  logic                      control_trigger_i,
  output dot_driver_pkg::dot_data_t driver_io_o [NUM_OF_DRIVERS],
  output logic                      update_done_o
);

  import dot_driver_pkg::*;

  logic                      wr_valid;
  mem_write_t                rx_wr;
  mem_write_t                core_wr;
  logic [NUM_OF_DRIVERS-1:0] core_we;
  scan_t                     scan;

  spi_frame_receiver u_spi_rx (
    .user_clock2_i (user_clock2_i),
    .arst_n_i      (arst_n_i),
    .sclk_i        (sclk_i),
    .mosi_i        (mosi_i),
    .ss_n_i        (ss_n_i),
    .wr_valid_o    (wr_valid),
    .wr_o          (rx_wr)
  );

  update_controller #(
    .NUM_OF_DRIVERS (NUM_OF_DRIVERS),
    .MEM_LENGTH     (MEM_LENGTH)
  ) u_ctrl (
    .user_clock2_i     (user_clock2_i),
    .arst_n_i          (arst_n_i),
    .wr_valid_i        (wr_valid),
    .wr_i              (rx_wr),
    .latch_data_i      (latch_data_i),
    .control_trigger_i (control_trigger_i),
    .core_we_o         (core_we),
    .wr_o              (core_wr),
    .scan_o            (scan),
    .update_done_o     (update_done_o)
  );

  // one core per pin pair, all on the same scan bus
  for (genvar i = 0; i < NUM_OF_DRIVERS; i++) begin : g_core
    driver_core #(
      .MEM_LENGTH (MEM_LENGTH)
    ) u_core (
      .user_clock2_i (user_clock2_i),
      .arst_n_i      (arst_n_i),
      .we_i          (core_we[i]),
      .wr_i          (core_wr),
      .scan_i        (scan),
      .driver_io_o   (driver_io_o[i])
    );
  end

endmodule

`default_nettype wire

//--- rtl/driver_core.sv
`timescale 1ns/1ps
`default_nettype none

module driver_core #(
  parameter int MEM_LENGTH = 48
) (
  input  logic                       user_clock2_i,
  input  logic                       arst_n_i,
  input  logic                       we_i,
  input  dot_driver_pkg::mem_write_t wr_i,
  input  dot_driver_pkg::scan_t      scan_i,
  output dot_driver_pkg::dot_data_t  driver_io_o
);

  import dot_driver_pkg::*;

  localparam mem_addr_t LAST_ADDR = mem_addr_t'(MEM_LENGTH - 1);

  // bank 0 and bank 1 pattern memories
  dot_data_t mem_q [2][MEM_LENGTH];
  logic      invert_q;
  logic      wr_bank;
  logic      pattern_we;
  dot_data_t rd_data;

  // writes go to the bank that is not being played
  assign wr_bank    = ~scan_i.bank;
  assign pattern_we = we_i && (wr_i.cmd == WR_PATTERN) && (wr_i.addr <= LAST_ADDR);
  assign rd_data    = mem_q[scan_i.bank][scan_i.addr];

  always_ff @(posedge user_clock2_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int b = 0; b < 2; b++) begin
        for (int a = 0; a < MEM_LENGTH; a++) begin
          mem_q[b][a] <= '0;
        end
      end
    end else if (pattern_we) begin
      mem_q[wr_bank][wr_i.addr] <= wr_i.data;
    end
  end

  // config frame, only data bit 0 counts
  always_ff @(posedge user_clock2_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      invert_q <= 1'b0;
    end else if (we_i && (wr_i.cmd == WR_CONFIG)) begin
      invert_q <= wr_i.data[0];
    end
  end

  always_ff @(posedge user_clock2_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      driver_io_o <= '0;
    end else if (scan_i.active) begin
      driver_io_o <= invert_q ? ~rd_data : rd_data;
    end else begin
      driver_io_o <= '0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/update_controller.sv
`timescale 1ns/1ps
`default_nettype none

module update_controller #(
  parameter int NUM_OF_DRIVERS = 8,
  parameter int MEM_LENGTH     = 48
) (
  input  logic                       user_clock2_i,
  input  logic                       arst_n_i,
  input  logic                       wr_valid_i,
  input  dot_driver_pkg::mem_write_t wr_i,
  input  logic                       latch_data_i,
  input  logic                       control_trigger_i,
  output logic [NUM_OF_DRIVERS-1:0]  core_we_o,
  output dot_driver_pkg::mem_write_t wr_o,
  output dot_driver_pkg::scan_t      scan_o,
  output logic                       update_done_o
);

  import dot_driver_pkg::*;

  localparam mem_addr_t LAST_ADDR = mem_addr_t'(MEM_LENGTH - 1);

  logic [NUM_OF_DRIVERS-1:0] core_we_d;
  logic                      bank_q;
  logic                      done_q;
  logic                      start;
  seq_state_e                state_q;
  mem_addr_t                 addr_q;

  // one-hot core select, idx out of range selects nothing
  always_comb begin
    core_we_d = '0;
    for (int i = 0; i < NUM_OF_DRIVERS; i++) begin
      core_we_d[i] = wr_valid_i && (wr_i.idx == drv_idx_t'(i));
    end
  end

  always_ff @(posedge user_clock2_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      core_we_o <= '0;
    end else begin
      core_we_o <= core_we_d;
    end
  end

  always_ff @(posedge user_clock2_i) begin
    if (wr_valid_i) begin
      wr_o <= wr_i;
    end
  end

  // latch swaps banks only between scans
  always_ff @(posedge user_clock2_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bank_q <= 1'b0;
    end else if (latch_data_i && (state_q == SEQ_IDLE)) begin
      bank_q <= ~bank_q;
    end
  end

  // no restart in the cycle that reports completion
  assign start = control_trigger_i && (state_q == SEQ_IDLE) && !done_q;

  always_ff @(posedge user_clock2_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= SEQ_IDLE;
      addr_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        SEQ_IDLE: begin
          if (start) begin
            state_q <= SEQ_SCAN;
            addr_q  <= '0;
          end
        end
        SEQ_SCAN: begin
          if (addr_q == LAST_ADDR) begin
            state_q <= SEQ_IDLE;
            addr_q  <= '0;
            done_q  <= 1'b1;
          end else begin
            addr_q <= addr_q + 1'b1;
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  assign scan_o.active = (state_q == SEQ_SCAN);
  assign scan_o.bank   = bank_q;
  assign scan_o.addr   = addr_q;
  assign update_done_o = done_q;

endmodule

`default_nettype wire

//--- rtl/spi_frame_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module spi_frame_receiver (
  input  logic                       user_clock2_i,
  input  logic                       arst_n_i,
  input  logic                       sclk_i,
  input  logic                       mosi_i,
  input  logic                       ss_n_i,
  output logic                       wr_valid_o,
  output dot_driver_pkg::mem_write_t wr_o
);

  import dot_driver_pkg::*;

  localparam int CNT_BITS = $clog2(FRAME_BITS);
  localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(FRAME_BITS - 1);

  // sclk has one extra stage for the edge detector
  logic [2:0]            sclk_sync_q;
  logic [1:0]            mosi_sync_q;
  logic [1:0]            ss_n_sync_q;
  logic                  sclk_rise;
  logic                  frame_done;
  logic [CNT_BITS-1:0]   bit_cnt_q;
  logic [FRAME_BITS-2:0] shift_q;
  frame_t                frame;

  // two-flop synchronizers, idle levels on reset
  always_ff @(posedge user_clock2_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sclk_sync_q <= '0;
      mosi_sync_q <= '0;
      ss_n_sync_q <= '1;
    end else begin
      sclk_sync_q <= {sclk_sync_q[1:0], sclk_i};
      mosi_sync_q <= {mosi_sync_q[0], mosi_i};
      ss_n_sync_q <= {ss_n_sync_q[0], ss_n_i};
    end
  end

  // mosi_sync_q[1] has the same age as sclk_sync_q[1]
  assign sclk_rise  = sclk_sync_q[1] && !sclk_sync_q[2];
  assign frame_done = sclk_rise && !ss_n_sync_q[1] && (bit_cnt_q == LAST_BIT);
  assign frame      = {shift_q, mosi_sync_q[1]};

  always_ff @(posedge user_clock2_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt_q <= '0;
      shift_q   <= '0;
    end else if (ss_n_sync_q[1]) begin
      // deselected, so a partial frame is dropped
      bit_cnt_q <= '0;
      shift_q   <= '0;
    end else if (sclk_rise) begin
      shift_q <= frame[FRAME_BITS-2:0];
      if (bit_cnt_q == LAST_BIT) begin
        bit_cnt_q <= '0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge user_clock2_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_valid_o <= 1'b0;
    end else begin
      wr_valid_o <= frame_done;
    end
  end

  // request payload, qualified by wr_valid_o
  always_ff @(posedge user_clock2_i) begin
    if (frame_done) begin
      wr_o <= frame_to_write(frame);
    end
  end

endmodule

`default_nettype wire

//--- rtl/dot_driver_pkg.sv
package dot_driver_pkg;

  // frame and field widths
  localparam int FRAME_BITS   = 12;
  localparam int DRV_IDX_BITS = 3;
  localparam int ADDR_BITS    = 6;
  localparam int DOT_BITS     = 2;

  typedef logic [ADDR_BITS-1:0]    mem_addr_t;
  typedef logic [DOT_BITS-1:0]     dot_data_t;
  typedef logic [DRV_IDX_BITS-1:0] drv_idx_t;
  typedef logic [FRAME_BITS-1:0]   frame_t;

  // top bit of every frame
  typedef enum logic {
    WR_PATTERN = 1'b0,
    WR_CONFIG  = 1'b1
  } wr_cmd_e;

  typedef struct packed {
    wr_cmd_e   cmd;
    drv_idx_t  idx;
    mem_addr_t addr;
    dot_data_t data;
  } mem_write_t;

  // broadcast to every driver core
  typedef struct packed {
    logic      active;
    logic      bank;
    mem_addr_t addr;
  } scan_t;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_SCAN
  } seq_state_e;

  // frame layout, msb first: cmd, idx, addr, data
  function automatic mem_write_t frame_to_write(frame_t frame);
    mem_write_t wr;
    wr.cmd  = wr_cmd_e'(frame[FRAME_BITS-1]);
    wr.idx  = frame[FRAME_BITS-2 -: DRV_IDX_BITS];
    wr.addr = frame[FRAME_BITS-2-DRV_IDX_BITS -: ADDR_BITS];
    wr.data = frame[DOT_BITS-1:0];
    return wr;
  endfunction

endpackage
